/* src/axi_defs_pkg.sv */
package axi_defs_pkg;

  // field widths of the AXI read-address channel
  localparam int addr_width = 16;
  localparam int id_width = 4;
  localparam int len_width = 8;
  localparam int size_width = 3;
  localparam int burst_width = 2;

  // burst type encodings as defined by AXI, code 3 is reserved
  localparam logic [burst_width-1:0] burst_fixed = 2'd0;
  localparam logic [burst_width-1:0] burst_incr = 2'd1;
  localparam logic [burst_width-1:0] burst_wrap = 2'd2;

endpackage

/* src/split_cfg_pkg.sv */
package split_cfg_pkg;

  // depth of the beat request FIFO, kept a power of two so the pointers wrap freely
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_width = 2;

  // the iterator either waits for a request or walks through a burst
  typedef enum logic {
    iter_idle,
    iter_burst
  } iter_state_t;

endpackage

/* src/burst_addr_gen.sv */
`timescale 1ns/1ps

module burst_addr_gen
  import axi_defs_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load,
  input  logic                   step,
  input  logic [addr_width-1:0]  start_addr,
  input  logic [size_width-1:0]  size,
  input  logic [burst_width-1:0] burst,
  input  logic [len_width-1:0]   wrap_len,
  output logic [addr_width-1:0]  beat_addr
);

  logic [size_width-1:0]  size_q;
  logic [burst_width-1:0] burst_q;
  logic [addr_width-1:0]  wrap_mask;
  logic [addr_width-1:0]  addr_inc;
  logic [addr_width-1:0]  incr_addr;
  logic [addr_width-1:0]  next_addr;

  assign addr_inc  = addr_width'(1) << size_q;
  assign incr_addr = beat_addr + addr_inc;

  always_comb begin
    case (burst_q)
      burst_fixed: next_addr = beat_addr;
      burst_incr:  next_addr = incr_addr;
      // low bits roll over inside the wrap window, high bits stay put
      burst_wrap:  next_addr = (beat_addr & ~wrap_mask) | (incr_addr & wrap_mask);
      // the reserved code steps like INCR
      default:     next_addr = incr_addr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_addr <= '0;
    end else if (load) begin
      beat_addr <= start_addr;
    end else if (step) begin
      beat_addr <= next_addr;
    end
  end

  // the wrap window spans (len+1) transfers of 2**size bytes
  always_ff @(posedge clk) begin
    if (load) begin
      size_q    <= size;
      burst_q   <= burst;
      wrap_mask <= ((addr_width'(wrap_len) + 1'b1) << size) - 1'b1;
    end
  end

  // a load in the middle of a burst would swallow the step of a pushed beat
  a_load_step_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(load && step))
    else $error("load and step in the same cycle");

endmodule

/* src/beat_req_fifo.sv */
`timescale 1ns/1ps

module beat_req_fifo
  import axi_defs_pkg::*;
  import split_cfg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  push,
  input  logic [addr_width-1:0] push_addr,
  input  logic [id_width-1:0]   push_id,
  input  logic [size_width-1:0] push_size,
  input  logic                  push_last,
  output logic                  full,

  output logic                  m_valid,
  output logic [addr_width-1:0] m_addr,
  output logic [id_width-1:0]   m_id,
  output logic [size_width-1:0] m_size,
  output logic                  m_last,
  input  logic                  m_ready
);

  logic [addr_width-1:0] addr_mem [fifo_depth];
  logic [id_width-1:0]   id_mem   [fifo_depth];
  logic [size_width-1:0] size_mem [fifo_depth];
  logic                  last_mem [fifo_depth];

  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  logic [fifo_ptr_width:0]   count;
  logic                      pop;

  assign pop     = m_valid && m_ready;
  assign m_valid = count != '0;
  assign full    = count == (fifo_ptr_width + 1)'(fifo_depth);

  // head entry is shown directly, so it stays put until popped
  assign m_addr = addr_mem[rd_ptr];
  assign m_id   = id_mem[rd_ptr];
  assign m_size = size_mem[rd_ptr];
  assign m_last = last_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr] <= push_addr;
      id_mem[wr_ptr]   <= push_id;
      size_mem[wr_ptr] <= push_size;
      last_mem[wr_ptr] <= push_last;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= (fifo_ptr_width + 1)'(fifo_depth))
    else $error("FIFO count above depth");

  a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable({m_addr, m_id, m_size, m_last}))
    else $error("manager beat changed while stalled");

endmodule

/* src/burst_iter_ctrl.sv */
`timescale 1ns/1ps

module burst_iter_ctrl
  import axi_defs_pkg::*;
  import split_cfg_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   s_valid,
  input  logic [addr_width-1:0]  s_addr,
  input  logic [id_width-1:0]    s_id,
  input  logic [len_width-1:0]   s_len,
  input  logic [size_width-1:0]  s_size,
  input  logic [burst_width-1:0] s_burst,
  output logic                   s_ready,

  output logic                   load,
  output logic                   step,
  output logic [addr_width-1:0]  start_addr,
  output logic [size_width-1:0]  size,
  output logic [burst_width-1:0] burst,
  output logic [len_width-1:0]   wrap_len,

  input  logic                   full,
  output logic                   push,
  output logic [id_width-1:0]    push_id,
  output logic [size_width-1:0]  push_size,
  output logic                   push_last
);

  iter_state_t           state;
  logic [len_width-1:0]  beats_left;
  logic [id_width-1:0]   burst_id;
  logic [size_width-1:0] burst_size;
  logic                  accept;

  assign accept = s_valid && s_ready;

  // the address generator samples the request fields in the accept cycle
  assign load       = accept;
  assign start_addr = s_addr;
  assign size       = s_size;
  assign burst      = s_burst;
  assign wrap_len   = s_len;

  // one beat per cycle whenever the FIFO has room
  assign push      = (state == iter_burst) && !full;
  assign push_last = push && (beats_left == '0);
  assign step      = push;

  assign push_id   = burst_id;
  assign push_size = burst_size;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= iter_idle;
      s_ready <= 1'b1;
    end else begin
      case (state)
        iter_idle: begin
          if (accept) begin
            state   <= iter_burst;
            s_ready <= 1'b0;
          end
        end
        iter_burst: begin
          // the final beat went into the FIFO, so take the next request
          if (push_last) begin
            state   <= iter_idle;
            s_ready <= 1'b1;
          end
        end
        default: begin
          state   <= iter_idle;
          s_ready <= 1'b1;
        end
      endcase
    end
  end

  // request fields held for the whole burst
  always_ff @(posedge clk) begin
    if (accept) begin
      burst_id   <= s_id;
      burst_size <= s_size;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beats_left <= '0;
    end else if (accept) begin
      beats_left <= s_len;
    end else if (push && !push_last) begin
      beats_left <= beats_left - 1'b1;
    end
  end

  // a full FIFO stalls the burst and freezes its beat count
  a_stall_holds_count: assert property (@(posedge clk) disable iff (!rst_n)
    state == iter_burst && full |=> state == iter_burst && $stable(beats_left))
    else $error("beat count moved while the FIFO was full");

  // the controller only goes idle once the beat count has run out
  a_idle_count_done: assert property (@(posedge clk) disable iff (!rst_n)
    state == iter_idle |-> beats_left == '0)
    else $error("beats left over while idle");

  // a new request must not be taken while beats of the current one remain
  a_ready_low_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
    state == iter_burst |-> !s_ready)
    else $error("s_ready high during a burst");

endmodule

/* src/burst_splitter.sv */
`timescale 1ns/1ps

module burst_splitter
  import axi_defs_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   s_valid,
  input  logic [addr_width-1:0]  s_addr,
  input  logic [id_width-1:0]    s_id,
  input  logic [len_width-1:0]   s_len,
  input  logic [size_width-1:0]  s_size,
  input  logic [burst_width-1:0] s_burst,
  output logic                   s_ready,

  output logic                   m_valid,
  output logic [addr_width-1:0]  m_addr,
  output logic [id_width-1:0]    m_id,
  output logic [size_width-1:0]  m_size,
  output logic                   m_last,
  input  logic                   m_ready
);

  logic                   load;
  logic                   step;
  logic [addr_width-1:0]  start_addr;
  logic [size_width-1:0]  size;
  logic [burst_width-1:0] burst;
  logic [len_width-1:0]   wrap_len;
  logic [addr_width-1:0]  beat_addr;
  logic                   full;
  logic                   push;
  logic [id_width-1:0]    push_id;
  logic [size_width-1:0]  push_size;
  logic                   push_last;

  burst_iter_ctrl burst_iter_ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_valid    (s_valid),
    .s_addr     (s_addr),
    .s_id       (s_id),
    .s_len      (s_len),
    .s_size     (s_size),
    .s_burst    (s_burst),
    .s_ready    (s_ready),
    .load       (load),
    .step       (step),
    .start_addr (start_addr),
    .size       (size),
    .burst      (burst),
    .wrap_len   (wrap_len),
    .full       (full),
    .push       (push),
    .push_id    (push_id),
    .push_size  (push_size),
    .push_last  (push_last)
  );

  burst_addr_gen burst_addr_gen_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .step       (step),
    .start_addr (start_addr),
    .size       (size),
    .burst      (burst),
    .wrap_len   (wrap_len),
    .beat_addr  (beat_addr)
  );

  beat_req_fifo beat_req_fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_addr  (beat_addr),
    .push_id    (push_id),
    .push_size  (push_size),
    .push_last  (push_last),
    .full       (full),
    .m_valid    (m_valid),
    .m_addr     (m_addr),
    .m_id       (m_id),
    .m_size     (m_size),
    .m_last     (m_last),
    .m_ready    (m_ready)
  );

endmodule

/* sim/clk_rst_gen.sv */
`timescale 1ns/1ps

module clk_rst_gen (
  output logic clk,
  output logic rst_n
);

  // 10 ns clock period
  localparam int half_period = 5;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // reset is released on a rising edge after 16 cycles
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* sim/burst_splitter_tb.sv */
`timescale 1ns/1ps

module burst_splitter_tb
  import axi_defs_pkg::*;
  import split_cfg_pkg::*;
();

  localparam int wait_limit = 1000;
  localparam int max_patterns = 32;

  logic                   clk;
  logic                   rst_n;
  logic                   s_valid;
  logic [addr_width-1:0]  s_addr;
  logic [id_width-1:0]    s_id;
  logic [len_width-1:0]   s_len;
  logic [size_width-1:0]  s_size;
  logic [burst_width-1:0] s_burst;
  logic                   s_ready;
  logic                   m_valid;
  logic [addr_width-1:0]  m_addr;
  logic [id_width-1:0]    m_id;
  logic [size_width-1:0]  m_size;
  logic                   m_last;
  logic                   m_ready = 1'b0;
  logic                   hold_low = 1'b0;

  // one count word, then six words per pattern
  logic [15:0] pat_mem [1 + 6 * max_patterns];

  logic [addr_width-1:0] exp_addr_q [$];
  logic [id_width-1:0]   exp_id_q   [$];
  logic [size_width-1:0] exp_size_q [$];
  logic                  exp_last_q [$];

  logic                  was_stalled = 1'b0;
  logic [addr_width-1:0] held_addr;
  logic [id_width-1:0]   held_id;
  logic [size_width-1:0] held_size;
  logic                  held_last;

  clk_rst_gen clk_rst_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  burst_splitter burst_splitter_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_addr  (s_addr),
    .s_id    (s_id),
    .s_len   (s_len),
    .s_size  (s_size),
    .s_burst (s_burst),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_addr  (m_addr),
    .m_id    (m_id),
    .m_size  (m_size),
    .m_last  (m_last),
    .m_ready (m_ready)
  );

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout after %0d cycles while waiting for %s", wait_limit, what);
    stop_with_failure();
  endtask

  task automatic check_addr(input string name, input logic [addr_width-1:0] exp_v,
                            input logic [addr_width-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH time %0t signal %s expected %h actual %h", $time, name, exp_v, act_v);
      stop_with_failure();
    end
  endtask

  task automatic check_id(input string name, input logic [id_width-1:0] exp_v,
                          input logic [id_width-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH time %0t signal %s expected %h actual %h", $time, name, exp_v, act_v);
      stop_with_failure();
    end
  endtask

  task automatic check_size(input string name, input logic [size_width-1:0] exp_v,
                            input logic [size_width-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH time %0t signal %s expected %h actual %h", $time, name, exp_v, act_v);
      stop_with_failure();
    end
  endtask

  task automatic check_last(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH time %0t signal %s expected %b actual %b", $time, name, exp_v, act_v);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH time %0t signal %s expected %b actual %b", $time, name, exp_v, act_v);
      stop_with_failure();
    end
  endtask

  // a wrap window holds (len+1) transfers and starts at a multiple of its own size
  function automatic logic [addr_width-1:0] next_beat_addr(
    input logic [addr_width-1:0]  addr,
    input logic [size_width-1:0]  size,
    input logic [burst_width-1:0] burst,
    input logic [len_width-1:0]   len
  );
    logic [addr_width-1:0] bytes;
    logic [addr_width-1:0] window;
    logic [addr_width-1:0] base;
    bytes  = addr_width'(1) << size;
    window = (addr_width'(len) + addr_width'(1)) * bytes;
    base   = addr - (addr % window);
    if (burst == burst_fixed) return addr;
    if (burst == burst_wrap) return base + ((addr - base + bytes) % window);
    return addr + bytes;
  endfunction

  task automatic expect_beats(
    input logic [addr_width-1:0]  addr,
    input logic [id_width-1:0]    id,
    input logic [len_width-1:0]   len,
    input logic [size_width-1:0]  size,
    input logic [burst_width-1:0] burst,
    input logic [addr_width-1:0]  last_addr
  );
    logic [addr_width-1:0] beat;
    beat = addr;
    for (int n = 0; n <= int'(len); n++) begin
      if (n == int'(len)) begin
        check_addr("model final address", last_addr, beat);
      end
      exp_addr_q.push_back(beat);
      exp_id_q.push_back(id);
      exp_size_q.push_back(size);
      exp_last_q.push_back(n == int'(len));
      beat = next_beat_addr(beat, size, burst, len);
    end
  endtask

  task automatic wait_for_ready();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles >= wait_limit) report_timeout("s_ready");
    end while (!s_ready);
  endtask

  task automatic send_request(
    input logic [addr_width-1:0]  addr,
    input logic [id_width-1:0]    id,
    input logic [len_width-1:0]   len,
    input logic [size_width-1:0]  size,
    input logic [burst_width-1:0] burst,
    input logic [addr_width-1:0]  last_addr
  );
    int cycles;
    wait_for_ready();
    s_valid <= 1'b1;
    s_addr  <= addr;
    s_id    <= id;
    s_len   <= len;
    s_size  <= size;
    s_burst <= burst;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles >= wait_limit) report_timeout("the request handshake");
    end while (!s_ready);
    expect_beats(addr, id, len, size, burst, last_addr);
    s_valid <= 1'b0;
  endtask

  task automatic drain_beats();
    int cycles;
    cycles = 0;
    while (exp_addr_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles >= wait_limit) report_timeout("m_valid with the remaining beats");
    end
  endtask

  // the manager side applies random back-pressure and checks beats and stall stability
  always @(posedge clk) begin
    if (rst_n) begin
      if (was_stalled) begin
        check_flag("m_valid held", 1'b1, m_valid);
        check_addr("m_addr held", held_addr, m_addr);
        check_id("m_id held", held_id, m_id);
        check_size("m_size held", held_size, m_size);
        check_last("m_last held", held_last, m_last);
      end
      if (m_valid && m_ready) begin
        if (exp_addr_q.size() == 0) begin
          $display("a beat arrived on the manager port when none was expected");
          stop_with_failure();
        end else begin
          check_addr("m_addr", exp_addr_q.pop_front(), m_addr);
          check_id("m_id", exp_id_q.pop_front(), m_id);
          check_size("m_size", exp_size_q.pop_front(), m_size);
          check_last("m_last", exp_last_q.pop_front(), m_last);
        end
      end
      was_stalled <= m_valid && !m_ready;
      held_addr   <= m_addr;
      held_id     <= m_id;
      held_size   <= m_size;
      held_last   <= m_last;
      m_ready     <= !hold_low && ($urandom_range(99) >= 30);
    end
  end

  initial begin
    int n_pat;
    int base;
    int cycles;
    int stall_len;
    void'($urandom(9255));
    s_valid = 1'b0;
    s_addr  = '0;
    s_id    = '0;
    s_len   = '0;
    s_size  = '0;
    s_burst = '0;
    $readmemh("sim/split_patterns.mem", pat_mem);
    n_pat = int'(pat_mem[0]);
    if (n_pat == 0) begin
      $display("the pattern file could not be read or holds no patterns");
      stop_with_failure();
    end
    if (n_pat > max_patterns) begin
      $display("the pattern file holds more patterns than the testbench can store");
      stop_with_failure();
    end

    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles >= wait_limit) report_timeout("the end of reset");
    end while (!rst_n);
    check_flag("s_ready after reset", 1'b1, s_ready);
    check_flag("m_valid after reset", 1'b0, m_valid);

    for (int p = 0; p < n_pat; p++) begin
      base = 1 + 6 * p;
      send_request(pat_mem[base], pat_mem[base + 1][id_width-1:0],
                   pat_mem[base + 2][len_width-1:0], pat_mem[base + 3][size_width-1:0],
                   pat_mem[base + 4][burst_width-1:0], pat_mem[base + 5]);
      repeat ($urandom_range(2)) @(posedge clk);
    end
    drain_beats();

    // a burst longer than the FIFO cannot finish while the manager side is stalled
    hold_low <= 1'b1;
    repeat (2) @(posedge clk);
    stall_len = 2 * fifo_depth - 1;
    send_request(16'h2000, 4'h9, len_width'(stall_len), 3'd2, burst_incr,
                 16'h2000 + addr_width'(4 * stall_len));
    repeat (10 * fifo_depth) begin
      @(posedge clk);
      check_flag("s_ready during stall", 1'b0, s_ready);
    end
    check_flag("m_valid during stall", 1'b1, m_valid);
    hold_low <= 1'b0;
    send_request(16'h3000, 4'h5, 8'd1, 3'd1, burst_incr, 16'h3002);
    drain_beats();
    @(posedge clk);
    check_flag("m_valid when idle", 1'b0, m_valid);

    $display("All tests passed");
    $finish;
  end

endmodule

/* sim/split_patterns.mem */
// first word: number of patterns, then one pattern per line
// columns: addr id len size burst last_addr (all hex)
0f
0100 1 00 2 1 0100
0200 2 03 2 1 020c
0300 3 07 0 0 0300
0404 4 03 2 2 0400
0538 5 07 3 2 0530
0610 6 0f 0 2 061f
0702 7 01 1 2 0700
0800 8 05 1 3 080a
0900 9 0f 2 1 093c
0a0c a 03 1 2 0a0a
fff8 b 03 2 1 0004
0c00 c 00 0 0 0c00
0d20 d 07 2 2 0d3c
0e06 e 0f 1 2 0e04
0f00 f 02 7 1 1000

/* burst_splitter.f */
src/axi_defs_pkg.sv
src/split_cfg_pkg.sv
src/burst_addr_gen.sv
src/beat_req_fifo.sv
src/burst_iter_ctrl.sv
src/burst_splitter.sv
sim/clk_rst_gen.sv
sim/burst_splitter_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = burst_splitter_tb
FILELIST  = burst_splitter.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
